/* Bender.yml */
package:
  name: dram_top

sources:
  - files:
      - hdl/dram_pkg.sv
      - hdl/wb_dram_port.sv
      - hdl/dram_arbiter.sv
      - hdl/dram_ctrl.sv
      - hdl/dram_top.sv
  - target: simulation
    files:
      - sim/dram_top_chk.sv
      - sim/tb_dram_top.sv

/* hdl/dram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_arbiter import dram_pkg::*; (
	input  wire        fclk,
	input  wire        rst_n,

	input  wire        cpu_req,
	input  word_addr_t cpu_addr,
	input  wire        cpu_rnw,
	input  bsel_t      cpu_bsel,
	input  word_t      cpu_wrdata,

	input  wire        dma_req,
	input  word_addr_t dma_addr,
	input  wire        dma_rnw,
	input  bsel_t      dma_bsel,
	input  word_t      dma_wrdata,

	output logic       cpu_grant,
	output logic       dma_grant,

	output phase_t     phase,
	output logic       slot_valid,
	output logic       slot_owner,
	output word_addr_t slot_addr,
	output logic       slot_rnw,
	output bsel_t      slot_bsel,
	output word_t      slot_wrdata
);

	logic last_phase;

	// free running c0..c3
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			phase <= PH_C0;
		else
			phase <= phase + 2'd1;
	end

	assign last_phase = (phase == PH_C3);

	// cpu first, dma takes what is left
	assign cpu_grant = last_phase & cpu_req;
	assign dma_grant = last_phase & dma_req & ~cpu_req;

	// owner: 0 cpu, 1 dma
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= 1'b0;
			slot_owner <= 1'b0;
		end else if (last_phase) begin
			slot_valid <= cpu_req | dma_req;
			slot_owner <= ~cpu_req;
		end
	end

	always_ff @(posedge fclk) begin
		if (last_phase) begin
			slot_addr   <= cpu_req ? cpu_addr   : dma_addr;
			slot_rnw    <= cpu_req ? cpu_rnw    : dma_rnw;
			slot_bsel   <= cpu_req ? cpu_bsel   : dma_bsel;
			slot_wrdata <= cpu_req ? cpu_wrdata : dma_wrdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/dram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl import dram_pkg::*; (
	input  wire        fclk,
	input  wire        rst_n,

	input  phase_t     phase,
	input  wire        slot_valid,
	input  wire        slot_owner,
	input  word_addr_t slot_addr,
	input  wire        slot_rnw,
	input  bsel_t      slot_bsel,
	input  word_t      slot_wrdata,

	output logic       cpu_done,
	output logic       dma_done,
	output word_t      rddata,

	output ra_t        dram_ra,
	output word_t      dram_wd,
	output logic       dram_wd_oe,
	input  word_t      dram_rd,
	output logic       rwe_n,
	output logic       rucas_n,
	output logic       rlcas_n,
	output logic       rras0_n,
	output logic       rras1_n
);

	logic bank;

	assign bank    = slot_addr[ADDR_W-1];
	assign dram_wd = slot_wrdata;

	// row stays up through the ras edge, column through the cas edge
	always_comb begin
		if (phase == PH_C0 || phase == PH_C1)
			dram_ra = slot_addr[2*RA_W-1:RA_W];
		else
			dram_ra = slot_addr[RA_W-1:0];
	end

	////////////////////
	// strobe sequencer
	////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			rras0_n    <= 1'b1;
			rras1_n    <= 1'b1;
			rucas_n    <= 1'b1;
			rlcas_n    <= 1'b1;
			rwe_n      <= 1'b1;
			dram_wd_oe <= 1'b0;
			cpu_done   <= 1'b0;
			dma_done   <= 1'b0;
		end else begin
			cpu_done <= 1'b0;
			dma_done <= 1'b0;
			case (phase)
				PH_C0: if (slot_valid) begin
					rras0_n    <= bank;
					rras1_n    <= ~bank;
					dram_wd_oe <= ~slot_rnw;
				end
				PH_C1: if (slot_valid)
					rwe_n <= slot_rnw;
				// reads open both lanes
				PH_C2: if (slot_valid) begin
					rucas_n <= ~(slot_rnw | slot_bsel[1]);
					rlcas_n <= ~(slot_rnw | slot_bsel[0]);
				end
				PH_C3: begin
					rras0_n    <= 1'b1;
					rras1_n    <= 1'b1;
					rucas_n    <= 1'b1;
					rlcas_n    <= 1'b1;
					rwe_n      <= 1'b1;
					dram_wd_oe <= 1'b0;
					cpu_done   <= slot_valid & ~slot_owner;
					dma_done   <= slot_valid & slot_owner;
				end
			endcase
		end
	end

	// cas is low during c3, data settles before the edge
	always_ff @(posedge fclk) begin
		if (phase == PH_C3)
			rddata <= dram_rd;
	end

endmodule

`default_nettype wire

/* hdl/dram_pkg.sv */
`default_nettype none

package dram_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int RA_W   = 10;
	localparam int ADDR_W = 21;
	localparam int WORD_W = 16;

	// bit 20 bank, 19..10 row, 9..0 column
	typedef logic [ADDR_W-1:0] word_addr_t;
	// word address on top, lane bit at the bottom
	typedef logic [ADDR_W:0]   byte_addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [7:0]        byte_t;
	// [1] upper byte (ucas), [0] lower byte (lcas)
	typedef logic [1:0]        bsel_t;
	typedef logic [RA_W-1:0]   ra_t;

	////////////////////
	// slot phases
	////////////////////

	typedef logic [1:0] phase_t;

	localparam phase_t PH_C0 = 2'd0;
	localparam phase_t PH_C1 = 2'd1;
	localparam phase_t PH_C2 = 2'd2;
	localparam phase_t PH_C3 = 2'd3;

endpackage

`default_nettype wire

/* hdl/dram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_top import dram_pkg::*; (
	input  wire        fclk,
	input  wire        rst_n,

	// cpu, byte wide
	input  wire        cpu_cyc,
	input  wire        cpu_stb,
	input  wire        cpu_we,
	input  byte_addr_t cpu_adr,
	input  byte_t      cpu_dat_w,
	output byte_t      cpu_dat_r,
	output logic       cpu_ack,

	// dma, word wide
	input  wire        dma_cyc,
	input  wire        dma_stb,
	input  wire        dma_we,
	input  word_addr_t dma_adr,
	input  word_t      dma_dat_w,
	output word_t      dma_dat_r,
	output logic       dma_ack,

	// dram pins
	output ra_t        dram_ra,
	output word_t      dram_wd,
	output logic       dram_wd_oe,
	input  word_t      dram_rd,
	output logic       rwe_n,
	output logic       rucas_n,
	output logic       rlcas_n,
	output logic       rras0_n,
	output logic       rras1_n
);

	logic       cpu_req, cpu_rnw, cpu_grant, cpu_done;
	word_addr_t cpu_addr;
	bsel_t      cpu_bsel;
	word_t      cpu_wrdata;

	logic       dma_req, dma_rnw, dma_grant, dma_done;
	word_addr_t dma_addr;
	bsel_t      dma_bsel;
	word_t      dma_wrdata;

	phase_t     phase;
	logic       slot_valid, slot_owner, slot_rnw;
	word_addr_t slot_addr;
	bsel_t      slot_bsel;
	word_t      slot_wrdata;
	word_t      rddata;

	wb_dram_port #(.addr_t(byte_addr_t), .data_t(byte_t)) cpu_port (
		.fclk(fclk), .rst_n(rst_n),
		.cyc(cpu_cyc), .stb(cpu_stb), .we(cpu_we), .adr(cpu_adr),
		.dat_w(cpu_dat_w), .dat_r(cpu_dat_r), .ack(cpu_ack),
		.req(cpu_req), .req_addr(cpu_addr), .req_rnw(cpu_rnw),
		.req_bsel(cpu_bsel), .req_wrdata(cpu_wrdata),
		.grant(cpu_grant), .done(cpu_done), .rddata(rddata)
	);

	wb_dram_port #(.addr_t(word_addr_t), .data_t(word_t)) dma_port (
		.fclk(fclk), .rst_n(rst_n),
		.cyc(dma_cyc), .stb(dma_stb), .we(dma_we), .adr(dma_adr),
		.dat_w(dma_dat_w), .dat_r(dma_dat_r), .ack(dma_ack),
		.req(dma_req), .req_addr(dma_addr), .req_rnw(dma_rnw),
		.req_bsel(dma_bsel), .req_wrdata(dma_wrdata),
		.grant(dma_grant), .done(dma_done), .rddata(rddata)
	);

	////////////////////
	// slot arbiter
	////////////////////

	dram_arbiter dramarb (
		.fclk(fclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_rnw(cpu_rnw),
		.cpu_bsel(cpu_bsel), .cpu_wrdata(cpu_wrdata),
		.dma_req(dma_req), .dma_addr(dma_addr), .dma_rnw(dma_rnw),
		.dma_bsel(dma_bsel), .dma_wrdata(dma_wrdata),
		.cpu_grant(cpu_grant), .dma_grant(dma_grant),
		.phase(phase), .slot_valid(slot_valid), .slot_owner(slot_owner),
		.slot_addr(slot_addr), .slot_rnw(slot_rnw), .slot_bsel(slot_bsel),
		.slot_wrdata(slot_wrdata)
	);

	dram_ctrl dram (
		.fclk(fclk), .rst_n(rst_n),
		.phase(phase), .slot_valid(slot_valid), .slot_owner(slot_owner),
		.slot_addr(slot_addr), .slot_rnw(slot_rnw), .slot_bsel(slot_bsel),
		.slot_wrdata(slot_wrdata),
		.cpu_done(cpu_done), .dma_done(dma_done), .rddata(rddata),
		.dram_ra(dram_ra), .dram_wd(dram_wd), .dram_wd_oe(dram_wd_oe),
		.dram_rd(dram_rd), .rwe_n(rwe_n), .rucas_n(rucas_n), .rlcas_n(rlcas_n),
		.rras0_n(rras0_n), .rras1_n(rras1_n)
	);

endmodule

`default_nettype wire

/* hdl/wb_dram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_dram_port import dram_pkg::*; #(
	parameter type addr_t = word_addr_t,
	parameter type data_t = word_t
) (
	input  wire        fclk,
	input  wire        rst_n,

	input  wire        cyc,
	input  wire        stb,
	input  wire        we,
	input  addr_t      adr,
	input  data_t      dat_w,
	output data_t      dat_r,
	output logic       ack,

	output logic       req,
	output word_addr_t req_addr,
	output logic       req_rnw,
	output bsel_t      req_bsel,
	output word_t      req_wrdata,
	input  wire        grant,
	input  wire        done,
	input  word_t      rddata
);

	localparam bit BYTE_WIDE = ($bits(data_t) == 8);

	logic lane;
	logic lane_q;
	// granted, slot still running
	logic pend;

	// byte clients carry the lane in the lowest address bit
	assign lane = BYTE_WIDE ? adr[0] : 1'b0;

	// master holds its fields until ack
	assign req        = cyc & stb & ~pend & ~ack;
	assign req_addr   = word_addr_t'(adr >> (BYTE_WIDE ? 1 : 0));
	assign req_rnw    = ~we;
	assign req_wrdata = word_t'({2{dat_w}});
	assign req_bsel   = BYTE_WIDE ? (lane ? 2'b10 : 2'b01) : 2'b11;

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= 1'b0;
			ack  <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (grant) begin
				pend <= 1'b1;
			end else if (done) begin
				pend <= 1'b0;
				ack  <= 1'b1;
			end
		end
	end

	// lane kept from grant to steer the returned word
	always_ff @(posedge fclk) begin
		if (grant)
			lane_q <= lane;
		if (done)
			dat_r <= data_t'(rddata >> (lane_q ? 8 : 0));
	end

endmodule

`default_nettype wire

/* project.f */
hdl/dram_pkg.sv
hdl/wb_dram_port.sv
hdl/dram_arbiter.sv
hdl/dram_ctrl.sv
hdl/dram_top.sv
sim/dram_top_chk.sv
sim/tb_dram_top.sv

/* sim/dram_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_top_chk (
	input wire fclk,
	input wire rst_n,
	input wire cpu_ack,
	input wire dma_ack,
	input wire rras0_n,
	input wire rras1_n,
	input wire rucas_n,
	input wire rlcas_n,
	input wire rwe_n,
	input wire dram_wd_oe
);

	int fail_cnt = 0;

	// single cycle acks
	cpu_ack_pulse: assert property (@(posedge fclk) disable iff (!rst_n)
		cpu_ack |=> !cpu_ack)
	else begin
		$error("cpu_ack held for more than one cycle");
		fail_cnt++;
	end

	dma_ack_pulse: assert property (@(posedge fclk) disable iff (!rst_n)
		dma_ack |=> !dma_ack)
	else begin
		$error("dma_ack held for more than one cycle");
		fail_cnt++;
	end

	one_bank: assert property (@(posedge fclk) disable iff (!rst_n)
		!(!rras0_n && !rras1_n))
	else begin
		$error("both ras lines low");
		fail_cnt++;
	end

	// cas only inside an open row
	cas_in_ras: assert property (@(posedge fclk) disable iff (!rst_n)
		(!rucas_n || !rlcas_n) |-> (!rras0_n || !rras1_n))
	else begin
		$error("cas low without ras");
		fail_cnt++;
	end

	we_with_oe: assert property (@(posedge fclk) disable iff (!rst_n)
		!rwe_n |-> dram_wd_oe)
	else begin
		$error("rwe_n low while write data not driven");
		fail_cnt++;
	end

endmodule

`default_nettype wire

/* sim/tb_dram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dram_top import dram_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DLY  = 1;
	localparam int N_WORDS    = 12;
	localparam int N_LANE     = 4;
	localparam int N_CONT     = 10;
	localparam int N_MIX      = 100;
	localparam int N_XFERS    = 6*N_WORDS + 3*N_LANE + 2*N_CONT + 2*N_MIX;
	localparam word_addr_t WIN_BASE = 21'h004C30;

	logic       fclk;
	logic       rst_n;
	logic       cpu_cyc, cpu_stb, cpu_we, cpu_ack;
	byte_addr_t cpu_adr;
	byte_t      cpu_dat_w, cpu_dat_r;
	logic       dma_cyc, dma_stb, dma_we, dma_ack;
	word_addr_t dma_adr;
	word_t      dma_dat_w, dma_dat_r;
	ra_t        dram_ra;
	word_t      dram_wd, dram_rd;
	logic       dram_wd_oe, rwe_n, rucas_n, rlcas_n, rras0_n, rras1_n;

	logic [15:0] lfsr = 16'd91;
	int          cycle_cnt = 0;
	int          cpu_ack_cyc;
	int          dma_ack_cyc;
	word_t       ref_mem [word_addr_t];
	word_t       dram_mem [word_addr_t];
	logic        dram_bank;
	ra_t         dram_row;
	word_addr_t  dram_word;

	dram_top UUT (
		.fclk(fclk), .rst_n(rst_n),
		.cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_adr(cpu_adr),
		.cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
		.dma_cyc(dma_cyc), .dma_stb(dma_stb), .dma_we(dma_we), .dma_adr(dma_adr),
		.dma_dat_w(dma_dat_w), .dma_dat_r(dma_dat_r), .dma_ack(dma_ack),
		.dram_ra(dram_ra), .dram_wd(dram_wd), .dram_wd_oe(dram_wd_oe),
		.dram_rd(dram_rd), .rwe_n(rwe_n), .rucas_n(rucas_n), .rlcas_n(rlcas_n),
		.rras0_n(rras0_n), .rras1_n(rras1_n)
	);

	bind dram_top dram_top_chk chk (
		.fclk(fclk), .rst_n(rst_n), .cpu_ack(cpu_ack), .dma_ack(dma_ack),
		.rras0_n(rras0_n), .rras1_n(rras1_n), .rucas_n(rucas_n),
		.rlcas_n(rlcas_n), .rwe_n(rwe_n), .dram_wd_oe(dram_wd_oe)
	);

	initial begin
		fclk = 1'b0;
		forever #(CLK_PERIOD/2) fclk = ~fclk;
	end

	always @(posedge fclk)
		cycle_cnt <= cycle_cnt + 1;

	////////////////////
	// helpers
	////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// bank and low column bits vary, the rest is fixed
	function automatic word_addr_t window_addr();
		word_addr_t a;
		a = WIN_BASE;
		a[ADDR_W-1] = rand_bits(1);
		a[3:0] = rand_bits(4);
		return a;
	endfunction

	function automatic word_t ref_read(input word_addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : '0;
	endfunction

	function automatic word_t dram_fetch(input word_addr_t a);
		return dram_mem.exists(a) ? dram_mem[a] : '0;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first error");
		end
	endtask

	////////////////////
	// dram model
	////////////////////

	always @(negedge rras0_n or negedge rras1_n) begin
		#DRIVE_DLY;
		dram_bank = ~rras1_n;
		dram_row  = dram_ra;
	end

	always @(negedge rucas_n or negedge rlcas_n) begin
		word_t w;
		#DRIVE_DLY;
		dram_word = {dram_bank, dram_row, dram_ra};
		if (!rwe_n) begin
			w = dram_fetch(dram_word);
			if (!rucas_n)
				w[15:8] = dram_wd[15:8];
			if (!rlcas_n)
				w[7:0] = dram_wd[7:0];
			dram_mem[dram_word] = w;
		end else begin
			dram_rd = dram_fetch(dram_word);
		end
	end

	always @(posedge rucas_n or posedge rlcas_n) begin
		#DRIVE_DLY;
		dram_rd = '0;
	end

	////////////////////
	// bus transfers
	////////////////////

	task automatic cpu_xfer(input string name, input logic we, input byte_addr_t adr,
			input byte_t wdat, output byte_t rdat);
		word_t w;
		cpu_cyc   = 1'b1;
		cpu_stb   = 1'b1;
		cpu_we    = we;
		cpu_adr   = adr;
		cpu_dat_w = wdat;
		do begin
			@(posedge fclk);
			#DRIVE_DLY;
		end while (!cpu_ack);
		cpu_ack_cyc = cycle_cnt;
		rdat    = cpu_dat_r;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		// odd byte address is the upper byte of the word
		w = ref_read(adr[ADDR_W:1]);
		if (we) begin
			if (adr[0])
				w[15:8] = wdat;
			else
				w[7:0] = wdat;
			ref_mem[adr[ADDR_W:1]] = w;
		end else begin
			check_value(name, adr[0] ? w[15:8] : w[7:0], rdat);
		end
		@(posedge fclk);
		#DRIVE_DLY;
	endtask

	task automatic dma_xfer(input string name, input logic we, input word_addr_t adr,
			input word_t wdat, output word_t rdat);
		dma_cyc   = 1'b1;
		dma_stb   = 1'b1;
		dma_we    = we;
		dma_adr   = adr;
		dma_dat_w = wdat;
		do begin
			@(posedge fclk);
			#DRIVE_DLY;
		end while (!dma_ack);
		dma_ack_cyc = cycle_cnt;
		rdat    = dma_dat_r;
		dma_cyc = 1'b0;
		dma_stb = 1'b0;
		if (we)
			ref_mem[adr] = wdat;
		else
			check_value(name, ref_read(adr), rdat);
		@(posedge fclk);
		#DRIVE_DLY;
	endtask

	task automatic cpu_mix();
		byte_addr_t a;
		byte_t      d;
		byte_t      r;
		logic       w;
		repeat (N_MIX) begin
			a = {window_addr(), 1'b0};
			a[0] = rand_bits(1);
			w = rand_bits(1);
			d = rand_bits(8);
			repeat (rand_bits(3)) begin
				@(posedge fclk);
				#DRIVE_DLY;
			end
			cpu_xfer("mix cpu read", w, a, d, r);
		end
	endtask

	task automatic dma_mix();
		word_addr_t a;
		word_t      d;
		word_t      r;
		logic       w;
		repeat (N_MIX) begin
			a = window_addr();
			w = rand_bits(1);
			d = rand_bits(16);
			repeat (rand_bits(3)) begin
				@(posedge fclk);
				#DRIVE_DLY;
			end
			dma_xfer("mix dma read", w, a, d, r);
		end
	endtask

	// 20 cycles per transfer plus reset
	initial begin
		#((N_XFERS*20 + 20) * CLK_PERIOD);
		$display("timeout: transfers did not finish within %0d cycles", N_XFERS*20 + 20);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

	initial begin
		word_addr_t addrs [N_WORDS];
		word_addr_t wa;
		word_t      wd;
		word_t      rd;
		byte_t      bd;
		byte_t      rb;
		logic       lane;
		logic       we;
		{cpu_cyc, cpu_stb, cpu_we, cpu_adr, cpu_dat_w} = '0;
		{dma_cyc, dma_stb, dma_we, dma_adr, dma_dat_w} = '0;
		dram_rd = '0;
		rst_n   = 1'b0;
		repeat (8) @(posedge fclk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		repeat (6) begin
			@(posedge fclk);
			#DRIVE_DLY;
			check_value("idle strobes", 32'h1f, {rras0_n, rras1_n, rucas_n, rlcas_n, rwe_n});
			check_value("idle acks", 32'h0, {cpu_ack, dma_ack, dram_wd_oe});
		end

		// cpu bytes in both lanes over the full address range
		for (int i = 0; i < N_WORDS; i++) begin
			addrs[i] = rand_bits(ADDR_W);
			bd = rand_bits(8);
			cpu_xfer("cpu write", 1'b1, {addrs[i], 1'b0}, bd, rb);
			bd = rand_bits(8);
			cpu_xfer("cpu write", 1'b1, {addrs[i], 1'b1}, bd, rb);
		end
		for (int i = 0; i < N_WORDS; i++) begin
			cpu_xfer("cpu read low lane", 1'b0, {addrs[i], 1'b0}, 8'h00, rb);
			cpu_xfer("cpu read high lane", 1'b0, {addrs[i], 1'b1}, 8'h00, rb);
		end

		for (int i = 0; i < N_WORDS; i++) begin
			addrs[i] = rand_bits(ADDR_W);
			wd = rand_bits(WORD_W);
			dma_xfer("dma write", 1'b1, addrs[i], wd, rd);
		end
		for (int i = 0; i < N_WORDS; i++)
			dma_xfer("dma read", 1'b0, addrs[i], 16'h0000, rd);

		repeat (N_LANE) begin
			wa = window_addr();
			wd = rand_bits(WORD_W);
			lane = rand_bits(1);
			bd = rand_bits(8);
			dma_xfer("lane dma write", 1'b1, wa, wd, rd);
			cpu_xfer("lane cpu write", 1'b1, {wa, lane}, bd, rb);
			dma_xfer("lane dma read", 1'b0, wa, 16'h0000, rd);
			check_value("lanes kept apart", lane ? {bd, wd[7:0]} : {wd[15:8], bd}, rd);
		end

		// same cycle stb on both ports
		repeat (N_CONT) begin
			wa = window_addr();
			we = rand_bits(1);
			wd = rand_bits(WORD_W);
			bd = rand_bits(8);
			lane = rand_bits(1);
			fork
				cpu_xfer("contention cpu read", we, {wa, lane}, bd, rb);
				dma_xfer("contention dma read", ~we, wa, wd, rd);
			join
			check_value("contention ack order", 32'h1, cpu_ack_cyc <= dma_ack_cyc);
		end

		fork
			cpu_mix();
			dma_mix();
		join

		if (UUT.chk.fail_cnt != 0) begin
			$display("%0d assertion failures on the dram pins or acks", UUT.chk.fail_cnt);
			$display("FAIL: see errors above");
			$fatal(1, "assertion failures");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire
